/* Makefile */
VERILATOR ?= verilator
TOP ?= maxicore32_tb
FILE_LIST ?= maxicore32.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --assert --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILE_LIST BUILD_DIR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

/* bus_interface.sv */
`timescale 1ns/1ps

module bus_interface import maxicore32_pkg::*; (
    input  bus_request_t  request,
    input  word_t         data_in,
    output word_t         load_data,
    output word_address_t address,
    output word_t         data_out,
    output logic [3:0]    data_strobes,
    output logic          read,
    output logic          write,
    output logic          bus_error
);

    logic [1:0] offset;
    logic [3:0] lane_strobes;
    logic       misaligned;
    logic       access;
    word_t      shifted_data;

    assign offset = request.address[1:0];
    assign access = request.read || request.write;

    always_comb begin
        case (request.width)
            cw_byte: begin
                misaligned   = 1'b0;
                lane_strobes = 4'b0001 << offset;
                data_out     = {4{request.write_data[7:0]}};
            end
            cw_word: begin
                misaligned   = offset[0];
                lane_strobes = offset[1] ? 4'b1100 : 4'b0011;
                data_out     = {2{request.write_data[15:0]}};
            end
            default: begin
                misaligned   = offset != 2'b00;
                lane_strobes = 4'b1111;
                data_out     = request.write_data;
            end
        endcase
    end

    // lane 0 carries the lowest byte address.
    assign shifted_data = data_in >> {offset, 3'b000};

    always_comb begin
        case (request.width)
            cw_byte: load_data = {24'h0, shifted_data[7:0]};
            cw_word: load_data = {16'h0, shifted_data[15:0]};
            default: load_data = data_in;
        endcase
    end

    assign address      = request.address[31:2];
    assign read         = request.read && !misaligned;
    assign write        = request.write && !misaligned;
    assign bus_error    = access && misaligned;
    assign data_strobes = (access && !misaligned) ? lane_strobes : 4'b0000;

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import maxicore32_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  word_t        mem_data,
    input  word_t        fetch_address,
    input  logic         capture,
    output instruction_t instruction,
    output word_t        instruction_address
);

    // a blocked or flushed fetch leaves a bubble behind.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            instruction <= nop_instruction;
        end else if (capture) begin
            instruction <= instruction_t'(mem_data);
        end else begin
            instruction <= nop_instruction;
        end
    end

    // address only matters alongside a captured word.
    always_ff @(posedge clock) begin
        if (capture) begin
            instruction_address <= fetch_address;
        end
    end

endmodule

/* maxicore32.f */
maxicore32_pkg.sv
bus_interface.sv
program_counter.sv
fetch_stage.sv
memory_stage.sv
register_file.sv
pipeline_control.sv
maxicore32.sv
maxicore32_tb.sv

/* maxicore32.sv */
`timescale 1ns/1ps

module maxicore32 import maxicore32_pkg::*; (
    input  logic          reset,
    input  logic          clock,
    output word_address_t address,
    input  word_t         data_in,
    output word_t         data_out,
    output logic [3:0]    data_strobes,
    output logic          read,
    output logic          write,
    output logic          bus_error
);

    bus_request_t request;
    word_t        load_data;
    word_t        pc;
    logic         pc_inc;
    logic         pc_jump;
    logic         pc_branch;
    logic         capture;
    instruction_t instruction;
    word_t        instruction_address;
    writeback_t   writeback;
    word_t        rd_value;
    word_t        rs_value;
    word_t        effective_address;
    word_t        store_data;

    bus_interface i_bus_interface (
        .request(request), .data_in(data_in), .load_data(load_data),
        .address(address), .data_out(data_out), .data_strobes(data_strobes),
        .read(read), .write(write), .bus_error(bus_error)
    );

    program_counter i_program_counter (
        .clock(clock), .reset(reset),
        .inc(pc_inc), .jump(pc_jump), .branch(pc_branch),
        .jump_data(rs_value), .branch_data(instruction.imm),
        .branch_base(instruction_address), .read_data(pc)
    );

    // fetches are long reads, so load_data is the raw word.
    fetch_stage i_fetch_stage (
        .clock(clock), .reset(reset),
        .mem_data(load_data), .fetch_address(pc), .capture(capture),
        .instruction(instruction), .instruction_address(instruction_address)
    );

    register_file i_register_file (
        .clock(clock), .reset(reset), .writeback(writeback),
        .rd_index(instruction.rd), .rs_index(instruction.rs),
        .rd_value(rd_value), .rs_value(rs_value)
    );

    memory_stage i_memory_stage (
        .clock(clock), .reset(reset), .instruction(instruction),
        .rd_value(rd_value), .rs_value(rs_value),
        .load_data(load_data), .bus_error(bus_error),
        .effective_address(effective_address), .store_data(store_data),
        .writeback(writeback)
    );

    pipeline_control i_pipeline_control (
        .clock(clock), .reset(reset), .instruction(instruction),
        .instruction_address(instruction_address),
        .rd_value(rd_value), .rs_value(rs_value), .pc(pc),
        .effective_address(effective_address), .store_data(store_data),
        .request(request), .pc_inc(pc_inc), .pc_jump(pc_jump),
        .pc_branch(pc_branch), .capture(capture)
    );

endmodule

/* maxicore32_pkg.sv */
package maxicore32_pkg;

    // data values and byte addresses.
    typedef logic [31:0] word_t;

    // long-word address as seen on the external bus.
    typedef logic [29:0] word_address_t;

    typedef logic [3:0] reg_index_t;
    typedef logic [15:0] imm_t;

    // unlisted codes execute as nop.
    typedef enum logic [3:0] {
        op_nop         = 4'h0,
        op_load_imm    = 4'h1,
        op_add         = 4'h2,
        op_load        = 4'h3,
        op_store       = 4'h4,
        op_branch_zero = 4'h5,
        op_jump        = 4'h6,
        op_halt        = 4'h7
    } opcode_t;

    typedef enum logic [1:0] {
        cw_byte = 2'b00,
        cw_word = 2'b01,
        cw_long = 2'b10
    } cycle_width_t;

    typedef struct packed {
        opcode_t      opcode;
        reg_index_t   rd;
        reg_index_t   rs;
        cycle_width_t width;
        logic [1:0]   reserved;
        imm_t         imm;
    } instruction_t;

    typedef struct packed {
        word_t        address;
        cycle_width_t width;
        word_t        write_data;
        logic         read;
        logic         write;
    } bus_request_t;

    typedef struct packed {
        logic       enable;
        reg_index_t rd;
        word_t      value;
    } writeback_t;

    localparam instruction_t nop_instruction = '0;
    localparam word_t reset_vector = 32'h0000_0000;

endpackage

/* maxicore32_tb.sv */
`timescale 1ns/1ps

module maxicore32_tb import maxicore32_pkg::*; ();

    typedef struct packed {
        word_address_t address;
        logic [3:0]    strobes;
        word_t         data;
    } store_t;

    logic          clock;
    logic          reset;
    word_address_t address;
    word_t         data_in;
    word_t         data_out;
    logic [3:0]    data_strobes;
    logic          read;
    logic          write;
    logic          bus_error;

    word_t  mem [512];
    word_t  ref_mem [512];
    store_t exp_store [64];
    store_t head;
    word_t  lcg_state = 32'd29755;
    int     prog_len = 0;
    int     exp_count = 0;
    int     exp_faults = 0;
    int     store_count = 0;
    int     fault_count = 0;
    int     idle_count = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    int     mismatch_count = 0;
    int     other_count = 0;
    logic   seen_read = 1'b0;

    maxicore32 i_maxicore32 (
        .reset(reset), .clock(clock), .address(address), .data_in(data_in),
        .data_out(data_out), .data_strobes(data_strobes), .read(read),
        .write(write), .bus_error(bus_error)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // single-cycle memory read combinationally and written at the edge.
    assign data_in = mem[address[8:0]];
    assign head = exp_store[store_count[5:0]];

    always @(posedge clock) begin
        if (write) begin
            for (int k = 0; k < 4; k++) begin
                if (data_strobes[k]) begin
                    mem[address[8:0]][8*k +: 8] <= data_out[8*k +: 8];
                end
            end
        end
    end

    always @(posedge clock) begin
        if (!reset) begin
            cycles <= cycles + 1;
            if (read) begin
                seen_read <= 1'b1;
            end
            if (write) begin
                store_count <= store_count + 1;
            end
            if (bus_error) begin
                fault_count <= fault_count + 1;
            end
            // two quiet cycles in a row only happen once halted.
            if (seen_read && !read && !write) begin
                idle_count <= idle_count + 1;
            end else begin
                idle_count <= 0;
            end
        end
    end

    task automatic report_mismatch(input string name, input word_t got, input word_t expected);
        mismatch_count++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic report_failure(input string what);
        other_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    reset_quiet: assert property (@(posedge clock) reset |-> !read && !write && !bus_error)
        else report_failure("bus active while reset is high");
    first_fetch: assert property (@(posedge clock) disable iff (reset)
        read && !seen_read |-> address == '0)
        else report_mismatch("address", word_t'($sampled(address)), '0);
    single_access: assert property (@(posedge clock) !(read && write))
        else report_failure("read and write high together");
    store_expected: assert property (@(posedge clock) disable iff (reset)
        write |-> store_count < exp_count)
        else report_failure("write beyond the expected stores");
    store_address: assert property (@(posedge clock) disable iff (reset)
        write |-> address == head.address)
        else report_mismatch("address", word_t'($sampled(address)),
            word_t'($sampled(head.address)));
    store_strobes: assert property (@(posedge clock) disable iff (reset)
        write |-> data_strobes == head.strobes)
        else report_mismatch("data_strobes", word_t'($sampled(data_strobes)),
            word_t'($sampled(head.strobes)));
    store_data: assert property (@(posedge clock) disable iff (reset)
        write |-> data_out == head.data)
        else report_mismatch("data_out", $sampled(data_out), $sampled(head.data));
    fault_quiet: assert property (@(posedge clock)
        bus_error |-> !read && !write && data_strobes == 4'b0000)
        else report_failure("bus access during bus error");
    halted_quiet: assert property (@(posedge clock) disable iff (reset)
        idle_count >= 2 |-> !read && !write)
        else report_failure("bus access after halt");

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic imm_t random_imm();
        word_t r;
        r = next_random();
        return r[31:16];
    endfunction

    function automatic word_t sign_extend(input imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // bytes moved by one access of each width.
    function automatic int access_bytes(input cycle_width_t width);
        case (width)
            cw_byte: return 1;
            cw_word: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic is_misaligned(input cycle_width_t width, input logic [1:0] off);
        return int'(off) % access_bytes(width) != 0;
    endfunction

    // a lane is strobed when its byte lies inside the access.
    function automatic logic [3:0] lane_mask(input cycle_width_t width, input logic [1:0] off);
        logic [3:0] mask;
        mask = '0;
        for (int k = 0; k < 4; k++) begin
            mask[k] = k >= int'(off) && k < int'(off) + access_bytes(width);
        end
        return mask;
    endfunction

    // the store value repeats across the word from lane 0 up.
    function automatic word_t lane_data(input cycle_width_t width, input word_t value);
        word_t data;
        for (int k = 0; k < 4; k++) begin
            data[8*k +: 8] = value[8*(k % access_bytes(width)) +: 8];
        end
        return data;
    endfunction

    function automatic word_t encode(input opcode_t op, input reg_index_t rd,
                                     input reg_index_t rs, input cycle_width_t width,
                                     input imm_t imm);
        instruction_t ins;
        ins = '{opcode: op, rd: rd, rs: rs, width: width, reserved: 2'b00, imm: imm};
        return word_t'(ins);
    endfunction

    task automatic emit(input opcode_t op, input reg_index_t rd, input reg_index_t rs,
                        input cycle_width_t width, input imm_t imm);
        mem[prog_len] = encode(op, rd, rs, width, imm);
        prog_len++;
    endtask

    task automatic build_program();
        for (int i = 0; i < 512; i++) begin
            mem[i] = next_random() ^ word_t'(i);
        end
        // r1 points at the data area while r2 and r3 carry dependent sums.
        emit(op_load_imm, 4'd1, 4'd0, cw_long, 16'h0400);
        emit(op_load_imm, 4'd2, 4'd0, cw_long, random_imm());
        emit(op_load_imm, 4'd3, 4'd0, cw_long, random_imm());
        emit(op_add, 4'd2, 4'd3, cw_long, 16'h0000);
        emit(op_store, 4'd2, 4'd1, cw_long, 16'h0000);
        emit(op_add, 4'd2, 4'd2, cw_long, 16'h0000);
        emit(op_store, 4'd2, 4'd1, cw_long, 16'h0004);
        for (int k = 0; k < 4; k++) begin
            emit(op_store, 4'd3, 4'd1, cw_byte, imm_t'(8 + k));
        end
        emit(op_store, 4'd3, 4'd1, cw_word, 16'h000c);
        emit(op_store, 4'd3, 4'd1, cw_word, 16'h000e);
        emit(op_load, 4'd5, 4'd1, cw_byte, 16'h0041);
        emit(op_store, 4'd5, 4'd1, cw_long, 16'h0020);
        emit(op_load, 4'd6, 4'd1, cw_word, 16'h0046);
        emit(op_store, 4'd6, 4'd1, cw_long, 16'h0024);
        emit(op_load, 4'd7, 4'd1, cw_long, 16'h0048);
        emit(op_store, 4'd7, 4'd1, cw_long, 16'h0028);
        // the store behind each taken branch or jump must never reach the bus.
        emit(op_branch_zero, 4'd0, 4'd0, cw_long, 16'h0002);
        emit(op_store, 4'd2, 4'd1, cw_long, 16'h0030);
        emit(op_branch_zero, 4'd1, 4'd0, cw_long, 16'h0002);
        emit(op_store, 4'd3, 4'd1, cw_long, 16'h0030);
        emit(op_load_imm, 4'd8, 4'd0, cw_long, imm_t'((prog_len + 3) * 4));
        emit(op_jump, 4'd0, 4'd8, cw_long, 16'h0000);
        emit(op_store, 4'd2, 4'd1, cw_long, 16'h0034);
        emit(op_store, 4'd8, 4'd1, cw_long, 16'h0034);
        emit(op_load_imm, 4'd9, 4'd0, cw_long, random_imm());
        emit(op_load, 4'd9, 4'd1, cw_word, 16'h0041);
        emit(op_store, 4'd9, 4'd1, cw_long, 16'h0052);
        emit(op_store, 4'd9, 4'd1, cw_long, 16'h0038);
        emit(op_halt, 4'd0, 4'd0, cw_long, 16'h0000);
    endtask

    // instruction-level model that retires one instruction per step.
    task automatic run_reference();
        word_t        regs [16];
        word_t        pc;
        word_t        next_pc;
        word_t        ea;
        word_t        value;
        instruction_t ins;
        logic [1:0]   off;
        logic [3:0]   mask;
        logic         write_rd;
        logic         stopped;
        int           steps;
        regs = '{default: '0};
        pc = reset_vector;
        value = '0;
        stopped = 1'b0;
        steps = 0;
        while (!stopped && steps < 200) begin
            ins = instruction_t'(ref_mem[pc[10:2]]);
            ea = regs[ins.rs] + sign_extend(ins.imm);
            off = ea[1:0];
            next_pc = pc + 32'd4;
            write_rd = 1'b0;
            steps++;
            case (ins.opcode)
                op_load_imm: begin
                    value = sign_extend(ins.imm);
                    write_rd = 1'b1;
                end
                op_add: begin
                    value = regs[ins.rd] + regs[ins.rs];
                    write_rd = 1'b1;
                end
                op_load: begin
                    if (is_misaligned(ins.width, off)) begin
                        exp_faults++;
                    end else begin
                        value = ref_mem[ea[10:2]] >> (8 * off);
                        if (ins.width == cw_byte) begin
                            value = value & 32'h0000_00ff;
                        end else if (ins.width == cw_word) begin
                            value = value & 32'h0000_ffff;
                        end
                        write_rd = 1'b1;
                    end
                end
                op_store: begin
                    if (is_misaligned(ins.width, off)) begin
                        exp_faults++;
                    end else begin
                        mask = lane_mask(ins.width, off);
                        value = lane_data(ins.width, regs[ins.rd]);
                        exp_store[exp_count] = '{address: ea[31:2], strobes: mask, data: value};
                        exp_count++;
                        for (int k = 0; k < 4; k++) begin
                            if (mask[k]) begin
                                ref_mem[ea[10:2]][8*k +: 8] = value[8*k +: 8];
                            end
                        end
                    end
                end
                op_branch_zero: begin
                    if (regs[ins.rd] == '0) begin
                        next_pc = pc + (sign_extend(ins.imm) << 2);
                    end
                end
                op_jump: next_pc = regs[ins.rs];
                op_halt: stopped = 1'b1;
                default: ;
            endcase
            if (write_rd && ins.rd != 4'd0) begin
                regs[ins.rd] = value;
            end
            pc = next_pc;
        end
    endtask

    initial begin
        reset = 1'b1;
        build_program();
        ref_mem = mem;
        run_reference();
        cycle_limit = 3 * prog_len + 20;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        while (idle_count < 6 && cycles < cycle_limit) begin
            @(negedge clock);
        end
        if (idle_count < 6) begin
            report_failure("timeout, core did not halt within the cycle limit");
        end
        if (!seen_read) begin
            report_failure("no fetch seen after reset");
        end
        if (store_count != exp_count) begin
            report_failure($sformatf("%0d stores seen, %0d expected", store_count, exp_count));
        end
        if (fault_count != exp_faults) begin
            report_failure($sformatf("%0d bus errors seen, %0d expected",
                                     fault_count, exp_faults));
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import maxicore32_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  instruction_t instruction,
    input  word_t        rd_value,
    input  word_t        rs_value,
    input  word_t        load_data,
    input  logic         bus_error,
    output word_t        effective_address,
    output word_t        store_data,
    output writeback_t   writeback
);

    word_t      imm_ext;
    logic       wb_enable_next;
    word_t      wb_value_next;
    logic       wb_enable;
    reg_index_t wb_rd;
    word_t      wb_value;

    assign imm_ext           = {{16{instruction.imm[15]}}, instruction.imm};
    assign effective_address = rs_value + imm_ext;
    assign store_data        = rd_value;

    always_comb begin
        wb_enable_next = 1'b0;
        wb_value_next  = imm_ext;
        case (instruction.opcode)
            op_load_imm: begin
                wb_enable_next = 1'b1;
            end
            op_add: begin
                wb_enable_next = 1'b1;
                wb_value_next  = rd_value + rs_value;
            end
            op_load: begin
                wb_enable_next = !bus_error;
                wb_value_next  = load_data;
            end
            default: ;
        endcase
        // r0 is never a destination.
        if (instruction.rd == 4'd0) begin
            wb_enable_next = 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_enable <= 1'b0;
        end else begin
            wb_enable <= wb_enable_next;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd    <= instruction.rd;
        wb_value <= wb_value_next;
    end

    assign writeback = '{enable: wb_enable, rd: wb_rd, value: wb_value};

endmodule

/* pipeline_control.sv */
`timescale 1ns/1ps

module pipeline_control import maxicore32_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  instruction_t instruction,
    input  word_t        instruction_address,
    input  word_t        rd_value,
    input  word_t        rs_value,
    input  word_t        pc,
    input  word_t        effective_address,
    input  word_t        store_data,
    output bus_request_t request,
    output logic         pc_inc,
    output logic         pc_jump,
    output logic         pc_branch,
    output logic         capture
);

    typedef enum logic {
        st_run,
        st_halted
    } state_t;

    state_t state;
    logic   started;
    logic   running;
    logic   is_load;
    logic   is_store;
    logic   is_halt;
    logic   block_fetch;
    logic   taken;
    logic   fetch_issue;
    word_t  branch_target;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= st_run;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (state == st_run && is_halt) begin
                state <= st_halted;
            end
        end
    end

    assign running     = started && state == st_run;
    assign is_load     = instruction.opcode == op_load;
    assign is_store    = instruction.opcode == op_store;
    assign is_halt     = instruction.opcode == op_halt;
    assign block_fetch = is_load || is_store;
    assign taken       = instruction.opcode == op_branch_zero && rd_value == '0;

    // a redirect onto the next sequential address keeps the word already fetched.
    assign branch_target = instruction_address
                         + {{14{instruction.imm[15]}}, instruction.imm, 2'b00};
    assign pc_branch     = taken && branch_target != pc;
    assign pc_jump       = instruction.opcode == op_jump && rs_value != pc;

    assign fetch_issue = running && !block_fetch && !is_halt;
    assign pc_inc      = fetch_issue;
    assign capture     = fetch_issue && !pc_branch && !pc_jump;

    always_comb begin
        request.address    = pc;
        request.width      = cw_long;
        request.write_data = store_data;
        request.read       = fetch_issue;
        request.write      = 1'b0;
        if (block_fetch) begin
            request.address = effective_address;
            request.width   = instruction.width;
            request.read    = is_load;
            request.write   = is_store;
        end
    end

endmodule

/* program_counter.sv */
`timescale 1ns/1ps

module program_counter import maxicore32_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  inc,
    input  logic  jump,
    input  logic  branch,
    input  word_t jump_data,
    input  imm_t  branch_data,
    input  word_t branch_base,
    output word_t read_data
);

    word_t pc;
    word_t branch_offset;

    // offset counts instructions, so scale by four.
    assign branch_offset = {{14{branch_data[15]}}, branch_data, 2'b00};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (jump) begin
            pc <= jump_data;
        end else if (branch) begin
            pc <= branch_base + branch_offset;
        end else if (inc) begin
            pc <= pc + 32'd4;
        end
    end

    assign read_data = pc;

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file import maxicore32_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  writeback_t writeback,
    input  reg_index_t rd_index,
    input  reg_index_t rs_index,
    output word_t      rd_value,
    output word_t      rs_value
);

    word_t registers [16];

    // the pending write is visible in the same cycle.
    function automatic word_t read_register(input reg_index_t index);
        word_t value;
        if (index == 4'd0) begin
            value = '0;
        end else if (writeback.enable && writeback.rd == index) begin
            value = writeback.value;
        end else begin
            value = registers[index];
        end
        return value;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                registers[i] <= '0;
            end
        end else if (writeback.enable && writeback.rd != 4'd0) begin
            registers[writeback.rd] <= writeback.value;
        end
    end

    assign rd_value = read_register(rd_index);
    assign rs_value = read_register(rs_index);

endmodule
